//--- common/eqPkg.sv
package eqPkg;

    // Q1.17 samples, weights and reference
    localparam int SampleWidth = 18;
    localparam int FracBits = 17;
    localparam int AccWidth = 40;

    localparam int WbAddrWidth = 3;
    localparam int WbDataWidth = 32;

    localparam logic [SampleWidth-1:0] DefaultRef = 18'h02000;
    localparam logic [SampleWidth-1:0] UnityWeight = 18'h1FFFF;

    // word addresses of the host register map
    typedef enum logic [WbAddrWidth-1:0] {
        CtrlReg    = 3'd0,
        RefReg     = 3'd1,
        TapSelReg  = 3'd2,
        TapRealReg = 3'd3,
        TapImagReg = 3'd4
    } regAddrT;

    typedef enum logic {
        BusIdle,
        BusAck
    } busStateT;

endpackage

//--- common/tapBus.sv
`timescale 1ns/10ps
interface tapBus #(
    parameter int NumTaps = 8
);

    // registered filter output
    logic signed [eqPkg::SampleWidth-1:0] yReal;
    logic signed [eqPkg::SampleWidth-1:0] yImag;

    // delay line that produced yReal/yImag
    logic signed [eqPkg::SampleWidth-1:0] xReal [NumTaps];
    logic signed [eqPkg::SampleWidth-1:0] xImag [NumTaps];

    logic signed [eqPkg::SampleWidth-1:0] wReal [NumTaps];
    logic signed [eqPkg::SampleWidth-1:0] wImag [NumTaps];

    modport filter (
        output yReal, yImag, xReal, xImag,
        input  wReal, wImag
    );

    modport update (
        input  yReal, yImag, xReal, xImag,
        output wReal, wImag
    );

endinterface

//--- common/coefBus.sv
`timescale 1ns/10ps
interface coefBus #(
    parameter int NumTaps = 8
);

    logic                                 adaptEnable;
    logic [2:0]                           stepSizeExponent;
    logic signed [eqPkg::SampleWidth-1:0] refLevel;

    // host access to one weight at a time
    logic [$clog2(NumTaps)-1:0]           tapSel;
    logic                                 tapWriteReal;
    logic                                 tapWriteImag;
    logic [eqPkg::SampleWidth-1:0]        tapWriteData;
    logic [eqPkg::SampleWidth-1:0]        tapReadReal;
    logic [eqPkg::SampleWidth-1:0]        tapReadImag;

    modport regs (
        output adaptEnable, stepSizeExponent, refLevel, tapSel,
        output tapWriteReal, tapWriteImag, tapWriteData,
        input  tapReadReal, tapReadImag
    );

    modport update (
        input  adaptEnable, stepSizeExponent, refLevel, tapSel,
        input  tapWriteReal, tapWriteImag, tapWriteData,
        output tapReadReal, tapReadImag
    );

endinterface

//--- src/eqRegs.sv
`timescale 1ns/10ps
module eqRegs #(
    parameter int NumTaps = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wbCyc,
    input  logic                            wbStb,
    input  logic                            wbWe,
    input  logic [eqPkg::WbAddrWidth-1:0]   wbAdr,
    input  logic [eqPkg::WbDataWidth-1:0]   wbWriteData,
    output logic [eqPkg::WbDataWidth-1:0]   wbReadData,
    output logic                            wbAck,
    coefBus.regs                            coef
);

    localparam int SelWidth = $clog2(NumTaps);
    localparam int PadWidth = eqPkg::WbDataWidth - eqPkg::SampleWidth;

    eqPkg::busStateT state;
    eqPkg::regAddrT  addr;
    logic            request;
    logic            writeHit;

    assign addr = eqPkg::regAddrT'(wbAdr);
    assign request = wbCyc && wbStb && (state == eqPkg::BusIdle);
    assign writeHit = request && wbWe;
    assign wbAck = (state == eqPkg::BusAck);

    // weight writes land on the same edge as register writes
    assign coef.tapWriteReal = writeHit && (addr == eqPkg::TapRealReg);
    assign coef.tapWriteImag = writeHit && (addr == eqPkg::TapImagReg);
    assign coef.tapWriteData = wbWriteData[eqPkg::SampleWidth-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= eqPkg::BusIdle;
            coef.adaptEnable <= 1'b0;
            coef.stepSizeExponent <= '0;
            coef.refLevel <= eqPkg::DefaultRef;
            coef.tapSel <= '0;
        end else begin
            if (state == eqPkg::BusIdle) begin
                if (request) begin
                    state <= eqPkg::BusAck;
                end
            end else begin
                state <= eqPkg::BusIdle;
            end

            if (writeHit) begin
                case (addr)
                    eqPkg::CtrlReg: begin
                        coef.adaptEnable <= wbWriteData[0];
                        coef.stepSizeExponent <= wbWriteData[3:1];
                    end
                    eqPkg::RefReg:    coef.refLevel <= wbWriteData[eqPkg::SampleWidth-1:0];
                    eqPkg::TapSelReg: coef.tapSel <= wbWriteData[SelWidth-1:0];
                    default: ;
                endcase
            end
        end
    end

    // address is held by the master, so the mux is valid during ack
    always_comb begin
        case (addr)
            eqPkg::CtrlReg:
                wbReadData = {{(eqPkg::WbDataWidth-4){1'b0}},
                              coef.stepSizeExponent, coef.adaptEnable};
            eqPkg::RefReg:
                wbReadData = {{PadWidth{1'b0}}, coef.refLevel};
            eqPkg::TapSelReg:
                wbReadData = {{(eqPkg::WbDataWidth-SelWidth){1'b0}}, coef.tapSel};
            eqPkg::TapRealReg:
                wbReadData = {{PadWidth{coef.tapReadReal[eqPkg::SampleWidth-1]}},
                              coef.tapReadReal};
            eqPkg::TapImagReg:
                wbReadData = {{PadWidth{coef.tapReadImag[eqPkg::SampleWidth-1]}},
                              coef.tapReadImag};
            default:
                wbReadData = '0;
        endcase
    end

endmodule

//--- equalizer/cmaFilter.sv
`timescale 1ns/10ps
module cmaFilter #(
    parameter int NumTaps = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 clkEn,
    input  logic signed [eqPkg::SampleWidth-1:0] iIn,
    input  logic signed [eqPkg::SampleWidth-1:0] qIn,
    tapBus.filter                                taps
);

    logic signed [eqPkg::SampleWidth-1:0] lineReal [NumTaps];
    logic signed [eqPkg::SampleWidth-1:0] lineImag [NumTaps];
    logic signed [eqPkg::AccWidth-1:0]    accReal;
    logic signed [eqPkg::AccWidth-1:0]    accImag;

    // clamp to the Q1.17 range
    function automatic logic signed [eqPkg::SampleWidth-1:0] saturate(
        input logic signed [eqPkg::AccWidth-1:0] value
    );
        logic [eqPkg::AccWidth-eqPkg::SampleWidth:0] upper;
        upper = value[eqPkg::AccWidth-1:eqPkg::SampleWidth-1];
        if (upper == '0 || upper == '1) begin
            return value[eqPkg::SampleWidth-1:0];
        end
        return {value[eqPkg::AccWidth-1], {(eqPkg::SampleWidth-1){~value[eqPkg::AccWidth-1]}}};
    endfunction

    // complex multiply-accumulate over all taps
    always_comb begin
        accReal = '0;
        accImag = '0;
        for (int i = 0; i < NumTaps; i++) begin
            accReal = accReal + lineReal[i] * taps.wReal[i] - lineImag[i] * taps.wImag[i];
            accImag = accImag + lineReal[i] * taps.wImag[i] + lineImag[i] * taps.wReal[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumTaps; i++) begin
                lineReal[i] <= '0;
                lineImag[i] <= '0;
                taps.xReal[i] <= '0;
                taps.xImag[i] <= '0;
            end
            taps.yReal <= '0;
            taps.yImag <= '0;
        end else if (clkEn) begin
            lineReal[0] <= iIn;
            lineImag[0] <= qIn;
            for (int i = 1; i < NumTaps; i++) begin
                lineReal[i] <= lineReal[i-1];
                lineImag[i] <= lineImag[i-1];
            end
            taps.yReal <= saturate(accReal >>> eqPkg::FracBits);
            taps.yImag <= saturate(accImag >>> eqPkg::FracBits);
            // snapshot keeps error and data aligned for the updater
            for (int i = 0; i < NumTaps; i++) begin
                taps.xReal[i] <= lineReal[i];
                taps.xImag[i] <= lineImag[i];
            end
        end
    end

endmodule

//--- equalizer/cmaUpdate.sv
`timescale 1ns/10ps
module cmaUpdate #(
    parameter int NumTaps = 8,
    parameter int CenterTap = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    clkEn,
    tapBus.update   taps,
    coefBus.update  coef
);

    logic signed [eqPkg::AccWidth-1:0] magSq;
    logic signed [eqPkg::AccWidth-1:0] diff;
    logic signed [eqPkg::AccWidth-1:0] errReal;
    logic signed [eqPkg::AccWidth-1:0] errImag;
    logic signed [eqPkg::AccWidth-1:0] deltaReal [NumTaps];
    logic signed [eqPkg::AccWidth-1:0] deltaImag [NumTaps];
    logic                              selValid;
    logic                              adapt;

    // constant-modulus error
    always_comb begin
        magSq = (taps.yReal * taps.yReal + taps.yImag * taps.yImag) >>> eqPkg::FracBits;
        diff = coef.refLevel - magSq;
        errReal = ((diff * taps.yReal) >>> eqPkg::FracBits) >>> coef.stepSizeExponent;
        errImag = ((diff * taps.yImag) >>> eqPkg::FracBits) >>> coef.stepSizeExponent;
    end

    // err times conj(x) per tap
    always_comb begin
        for (int i = 0; i < NumTaps; i++) begin
            deltaReal[i] = (errReal * taps.xReal[i] + errImag * taps.xImag[i])
                           >>> eqPkg::FracBits;
            deltaImag[i] = (errImag * taps.xReal[i] - errReal * taps.xImag[i])
                           >>> eqPkg::FracBits;
        end
    end

    assign adapt = clkEn && coef.adaptEnable;

    // host writes are not tied to clkEn and take priority over adaptation
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NumTaps; i++) begin
                taps.wReal[i] <= (i == CenterTap) ? eqPkg::UnityWeight : '0;
                taps.wImag[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumTaps; i++) begin
                if (coef.tapWriteReal && int'(coef.tapSel) == i) begin
                    taps.wReal[i] <= coef.tapWriteData;
                end else if (adapt) begin
                    taps.wReal[i] <= taps.wReal[i] + deltaReal[i][eqPkg::SampleWidth-1:0];
                end

                if (coef.tapWriteImag && int'(coef.tapSel) == i) begin
                    taps.wImag[i] <= coef.tapWriteData;
                end else if (adapt) begin
                    taps.wImag[i] <= taps.wImag[i] + deltaImag[i][eqPkg::SampleWidth-1:0];
                end
            end
        end
    end

    // tapSel may point past the last tap when NumTaps is not a power of two
    assign selValid = int'(coef.tapSel) < NumTaps;
    assign coef.tapReadReal = selValid ? taps.wReal[coef.tapSel] : '0;
    assign coef.tapReadImag = selValid ? taps.wImag[coef.tapSel] : '0;

endmodule

//--- src/cmaEqualizerTop.sv
`timescale 1ns/10ps
module cmaEqualizerTop #(
    parameter int NumTaps = 8,
    parameter int CenterTap = 3
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 clkEn,
    input  logic signed [eqPkg::SampleWidth-1:0] iIn,
    input  logic signed [eqPkg::SampleWidth-1:0] qIn,
    output logic signed [eqPkg::SampleWidth-1:0] iOut,
    output logic signed [eqPkg::SampleWidth-1:0] qOut,
    input  logic                                 wbCyc,
    input  logic                                 wbStb,
    input  logic                                 wbWe,
    input  logic [eqPkg::WbAddrWidth-1:0]        wbAdr,
    input  logic [eqPkg::WbDataWidth-1:0]        wbWriteData,
    output logic [eqPkg::WbDataWidth-1:0]        wbReadData,
    output logic                                 wbAck
);

    tapBus  #(.NumTaps(NumTaps)) taps ();
    coefBus #(.NumTaps(NumTaps)) coef ();

    eqRegs #(
        .NumTaps    (NumTaps)
    ) eqRegs_i (
        .clk        (clk),
        .reset      (reset),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbWriteData(wbWriteData),
        .wbReadData (wbReadData),
        .wbAck      (wbAck),
        .coef       (coef.regs)
    );

    cmaFilter #(
        .NumTaps(NumTaps)
    ) cmaFilter_i (
        .clk    (clk),
        .reset  (reset),
        .clkEn  (clkEn),
        .iIn    (iIn),
        .qIn    (qIn),
        .taps   (taps.filter)
    );

    cmaUpdate #(
        .NumTaps  (NumTaps),
        .CenterTap(CenterTap)
    ) cmaUpdate_i (
        .clk      (clk),
        .reset    (reset),
        .clkEn    (clkEn),
        .taps     (taps.update),
        .coef     (coef.update)
    );

    assign iOut = taps.yReal;
    assign qOut = taps.yImag;

endmodule

//--- sim/eqChecker.sv
`timescale 1ns/10ps
module eqChecker (
    input logic                                 clk,
    input logic signed [eqPkg::SampleWidth-1:0] iOut,
    input logic signed [eqPkg::SampleWidth-1:0] qOut,
    input logic [eqPkg::WbDataWidth-1:0]        wbReadData,
    input logic                                 wbAck
);

    int errorCount = 0;
    int checkCount = 0;
    int testCount = 0;
    int testErrors = 0;
    int testChecks = 0;
    int ackCount = 0;
    int accessCount = 0;

    // one count per acknowledged cycle
    always @(posedge clk) begin
        if (wbAck) begin
            ackCount++;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        checkCount++;
        testChecks++;
        if (got !== expected) begin
            errorCount++;
            testErrors++;
            $display("Mismatch %s: got %0h, expected %0h", name, got, expected);
        end
    endtask

    task automatic checkRead(input logic [31:0] expected);
        compareValue("wbReadData", wbReadData, expected);
    endtask

    task automatic checkOutputs(input logic [31:0] expI, input logic [31:0] expQ);
        compareValue("iOut", {14'd0, iOut}, expI);
        compareValue("qOut", {14'd0, qOut}, expQ);
    endtask

    task automatic noteAccess();
        accessCount++;
    endtask

    task automatic reportProblem(input string msg);
        errorCount++;
        testErrors++;
        $display("%s", msg);
    endtask

    task automatic endTest(input int testNum);
        compareValue("wbAck count", ackCount, accessCount);
        testCount++;
        $display("test %0d: %s (%0d checks, %0d errors)", testNum,
                 (testErrors == 0) ? "ok" : "FAILED", testChecks, testErrors);
        testErrors = 0;
        testChecks = 0;
        ackCount = 0;
        accessCount = 0;
    endtask

    task automatic closeRun();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    endtask

endmodule

//--- sim/cmaEqualizerTb.sv
`timescale 1ns/10ps
module cmaEqualizerTb;

    localparam int NumTaps = 8;
    localparam int ClkPeriod = 8;

    logic                                 clk;
    logic                                 reset;
    logic                                 clkEn;
    logic signed [eqPkg::SampleWidth-1:0] iIn;
    logic signed [eqPkg::SampleWidth-1:0] qIn;
    logic signed [eqPkg::SampleWidth-1:0] iOut;
    logic signed [eqPkg::SampleWidth-1:0] qOut;
    logic                                 wbCyc;
    logic                                 wbStb;
    logic                                 wbWe;
    logic [eqPkg::WbAddrWidth-1:0]        wbAdr;
    logic [eqPkg::WbDataWidth-1:0]        wbWriteData;
    logic [eqPkg::WbDataWidth-1:0]        wbReadData;
    logic                                 wbAck;

    // golden records
    int          recTest [$];
    logic [7:0]  recOp [$];
    logic [31:0] recA [$];
    logic [31:0] recB [$];
    logic [31:0] recC [$];
    logic [31:0] recD [$];
    longint      runLimit = 0;

    cmaEqualizerTop #(
        .NumTaps    (NumTaps),
        .CenterTap  (3)
    ) cmaEqualizerTop_i (
        .clk        (clk),
        .reset      (reset),
        .clkEn      (clkEn),
        .iIn        (iIn),
        .qIn        (qIn),
        .iOut       (iOut),
        .qOut       (qOut),
        .wbCyc      (wbCyc),
        .wbStb      (wbStb),
        .wbWe       (wbWe),
        .wbAdr      (wbAdr),
        .wbWriteData(wbWriteData),
        .wbReadData (wbReadData),
        .wbAck      (wbAck)
    );

    eqChecker checker_i (
        .clk        (clk),
        .iOut       (iOut),
        .qOut       (qOut),
        .wbReadData (wbReadData),
        .wbAck      (wbAck)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic bit loadGolden();
        int         fd;
        int         n;
        string      line;
        int         t;
        logic [7:0] op;
        logic [31:0] a, b, c, d;
        fd = $fopen("sim/eqGolden.dat", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %s %h %h %h %h", t, op, a, b, c, d);
            if (n == 6) begin
                recTest.push_back(t);
                recOp.push_back(op);
                recA.push_back(a);
                recB.push_back(b);
                recC.push_back(c);
                recD.push_back(d);
            end
        end
        $fclose(fd);
        return recOp.size() > 0;
    endfunction

    // rough cycle cost of one record
    function automatic int recordCycles(input int k);
        case (recOp[k])
            "S": return recD[k] + 1;
            "P": return NumTaps * 3 * 4;
            default: return 4;
        endcase
    endfunction

    task automatic busAccess(input logic we, input logic [31:0] adr, input logic [31:0] data);
        int waited;
        bit acked;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr[eqPkg::WbAddrWidth-1:0];
        wbWriteData = we ? data : '0;
        waited = 0;
        acked = 1'b0;
        while (!acked && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
            acked = wbAck;
        end
        checker_i.noteAccess();
        if (!acked) begin
            checker_i.reportProblem($sformatf("No wbAck within 4 cycles for address %0d", adr));
        end else if (!we) begin
            // read data is valid while wbAck is high
            checker_i.checkRead(data);
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic runRecord(input int k);
        case (recOp[k])
            "W": busAccess(1'b1, recA[k], recB[k]);
            "R": busAccess(1'b0, recA[k], recB[k]);
            "S": begin
                clkEn = recA[k][0];
                iIn = recB[k][eqPkg::SampleWidth-1:0];
                qIn = recC[k][eqPkg::SampleWidth-1:0];
                repeat (recD[k]) begin
                    @(posedge clk);
                    #1;
                end
            end
            "E": checker_i.checkOutputs(recB[k] & 32'h3FFFF, recC[k] & 32'h3FFFF);
            "P": begin
                // same weight into every tap
                for (int tap = 0; tap < NumTaps; tap++) begin
                    busAccess(1'b1, 32'(eqPkg::TapSelReg), tap);
                    busAccess(1'b1, 32'(eqPkg::TapRealReg), recB[k]);
                    busAccess(1'b1, 32'(eqPkg::TapImagReg), recC[k]);
                end
            end
            "T": checker_i.endTest(recTest[k]);
            default: checker_i.reportProblem($sformatf("Unknown golden operation in record %0d", k));
        endcase
    endtask

    initial begin
        longint cycles;
        clk = 1'b0;
        reset = 1'b1;
        clkEn = 1'b0;
        iIn = '0;
        qIn = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbWriteData = '0;
        if (!loadGolden()) begin
            $display("Could not read any records from sim/eqGolden.dat");
            $display("Checks failed");
            $finish;
        end else begin
            cycles = 0;
            for (int k = 0; k < recOp.size(); k++) begin
                cycles += recordCycles(k);
            end
            runLimit = (cycles + 5) * ClkPeriod + 200;
            repeat (5) @(posedge clk);
            #1;
            reset = 1'b0;
            for (int k = 0; k < recOp.size(); k++) begin
                runRecord(k);
            end
            checker_i.closeRun();
            if (checker_i.errorCount == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (runLimit > 0);
        #(runLimit);
        $display("Timeout: run did not finish within %0d ns", runLimit);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- sim/eqGolden.dat
# test op a b c d, operands in hex
# W addr data | R addr expected | S clkEn i q count | E - iOut qOut | P - real imag | T end
1 R 0 00000000 0 0
1 R 1 00002000 0 0
1 W 0 0000000C 0 0
1 R 0 0000000C 0 0
1 W 1 00001234 0 0
1 R 1 00001234 0 0
1 W 2 00000005 0 0
1 R 2 00000005 0 0
1 R 7 00000000 0 0
1 W 0 00000000 0 0
1 W 1 00002000 0 0
1 T 0 0 0 0
2 S 1 08000 38000 1
2 S 1 0 0 3
2 E 0 0 0 0
2 S 1 0 0 1
2 E 0 07FFF 38000 0
2 S 1 0 0 8
2 T 0 0 0 0
3 W 2 0 0 0
3 W 3 02000 0 0
3 W 4 3FC00 0 0
3 W 2 1 0 0
3 W 3 04000 0 0
3 W 4 3F800 0 0
3 W 2 2 0 0
3 W 3 06000 0 0
3 W 4 3F400 0 0
3 W 2 3 0 0
3 W 3 08000 0 0
3 W 4 3F000 0 0
3 W 2 4 0 0
3 W 3 0A000 0 0
3 W 4 3EC00 0 0
3 W 2 5 0 0
3 W 3 0C000 0 0
3 W 4 3E800 0 0
3 W 2 6 0 0
3 W 3 0E000 0 0
3 W 4 3E400 0 0
3 W 2 7 0 0
3 W 3 10000 0 0
3 W 4 3E000 0 0
3 R 3 00010000 0 0
3 R 4 FFFFE000 0 0
3 S 1 10000 0 1
3 S 1 0 0 1
3 E 0 01000 3FE00 0
3 S 1 0 0 1
3 E 0 02000 3FC00 0
3 S 1 0 0 1
3 E 0 03000 3FA00 0
3 S 1 0 0 1
3 E 0 04000 3F800 0
3 T 0 0 0 0
4 S 0 1FFFF 1FFFF 4
4 E 0 04000 3F800 0
4 S 1 0 0 1
4 E 0 05000 3F600 0
4 S 1 0 0 1
4 E 0 06000 3F400 0
4 S 1 0 0 1
4 E 0 07000 3F200 0
4 S 1 0 0 1
4 E 0 08000 3F000 0
4 S 1 0 0 8
4 T 0 0 0 0
5 W 0 00000005 0 0
5 S 1 10000 0 1
5 S 1 0 0 2
5 S 0 0 0 1
5 W 2 0 0 0
5 R 3 0000201F 0 0
5 R 4 FFFFFBFC 0 0
5 W 0 0 0 0
5 T 0 0 0 0
6 P 0 1FFFF 0 0
6 S 1 1FFFF 0 9
6 E 0 1FFFF 0 0
6 T 0 0 0 0

//--- verilog.f
common/eqPkg.sv
common/tapBus.sv
common/coefBus.sv
src/eqRegs.sv
equalizer/cmaFilter.sv
equalizer/cmaUpdate.sv
src/cmaEqualizerTop.sv
sim/eqChecker.sv
sim/cmaEqualizerTb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= cmaEqualizerTb
RTL_TOP   ?= cmaEqualizerTop
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
